// ==== rtl/st_mem_pkg.sv ====
package st_mem_pkg;

	// word address covers byte address bits 23 to 1
	localparam int ADDR_W = 23;
	localparam int DATA_W = 16;

	// ram size select, codes 6 and 7 leave the machine without ram
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// origin of a candidate request
	typedef enum logic [1:0] {
		SRC_DL  = 2'd0,
		SRC_RAM = 2'd1,
		SRC_ROM = 2'd2
	} req_src_e;

	// one queued memory access
	typedef struct packed {
		logic [ADDR_W:1]   addr;
		logic [DATA_W-1:0] data;
		logic              we;
		logic              uds;
		logic              lds;
		logic              rom;
	} mem_req_t;

	// rom window bases as word addresses (E00000 and FC0000)
	localparam logic [ADDR_W:1] ROM_BASE_STD  = 23'h70_0000;
	localparam logic [ADDR_W:1] ROM_BASE_192K = 23'h7E_0000;

	// bus slot where the cpu pre-cycle happens
	localparam logic [1:0] SLOT_PRECYCLE = 2'd0;

endpackage

// ==== rtl/st_req_capture.sv ====
`timescale 1ns/1ps

module st_req_capture (
	input  logic                              clk_32,
	input  logic                              xsint,
	input  logic                              ras_n_i,
	input  logic                              ref_i,
	input  logic                              we_n_i,
	input  logic                              uds_i,
	input  logic                              lds_i,
	input  logic [st_mem_pkg::ADDR_W:1]       ram_a_i,
	input  logic [st_mem_pkg::DATA_W-1:0]     ram_din_i,
	input  logic                              rom_n_i,
	input  logic [st_mem_pkg::ADDR_W:1]       mbus_a_i,
	input  logic                              data_download_i,
	input  logic [st_mem_pkg::ADDR_W:1]       data_addr_i,
	input  logic [st_mem_pkg::DATA_W-1:0]     data_in_reg_i,
	input  logic                              data_in_strobe_i,
	output logic                              cand_valid_o,
	output st_mem_pkg::req_src_e              cand_src_o,
	output logic [st_mem_pkg::ADDR_W:1]       cand_addr_o,
	output logic [st_mem_pkg::DATA_W-1:0]     cand_data_o,
	output logic                              cand_we_o,
	output logic [1:0]                        cand_sel_o
);

	logic [1:0]                    div_cnt;
	logic                          clk8_en;
	logic [1:0]                    slot;
	logic                          precycle_en;
	logic                          strobe_d;
	logic                          ras_n_d;
	logic                          rom_n_d;
	logic                          dl_hit;
	logic                          ram_fall;
	logic                          rom_fall;
	logic                          ram_pend_v;
	logic [st_mem_pkg::ADDR_W:1]   ram_pend_addr;
	logic [st_mem_pkg::DATA_W-1:0] ram_pend_data;
	logic                          ram_pend_we;
	logic [1:0]                    ram_pend_sel;
	logic                          rom_pend_v;
	logic [st_mem_pkg::ADDR_W:1]   rom_pend_addr;
	logic                          grant_dl;
	logic                          grant_ram;
	logic                          grant_rom;

	// 32 MHz divided by four gives the 8 MHz bus enable
	assign clk8_en     = (div_cnt == 2'd3);
	assign precycle_en = clk8_en && (slot == st_mem_pkg::SLOT_PRECYCLE);

	// a strobe toggle counts as one downloaded word
	assign dl_hit   = precycle_en && data_download_i && (data_in_strobe_i ^ strobe_d);
	assign ram_fall = ras_n_d && !ras_n_i && !ref_i;
	assign rom_fall = rom_n_d && !rom_n_i;

	// download wins, then chipset, then rom
	assign grant_dl  = dl_hit;
	assign grant_ram = !dl_hit && (ram_fall || ram_pend_v);
	assign grant_rom = !dl_hit && !(ram_fall || ram_pend_v) && (rom_fall || rom_pend_v);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt      <= 2'd0;
			slot         <= st_mem_pkg::SLOT_PRECYCLE;
			strobe_d     <= 1'b0;
			ras_n_d      <= 1'b1;
			rom_n_d      <= 1'b1;
			ram_pend_v   <= 1'b0;
			rom_pend_v   <= 1'b0;
			cand_valid_o <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 2'd1;
			if (clk8_en)
				slot <= slot + 2'd1;
			if (precycle_en)
				strobe_d <= data_in_strobe_i;
			ras_n_d <= ras_n_i;
			rom_n_d <= rom_n_i;
			// an event that is not taken waits in its pending slot
			if (ram_pend_v)
				ram_pend_v <= grant_ram ? ram_fall : 1'b1;
			else
				ram_pend_v <= ram_fall && !grant_ram;
			if (rom_pend_v)
				rom_pend_v <= grant_rom ? rom_fall : 1'b1;
			else
				rom_pend_v <= rom_fall && !grant_rom;
			cand_valid_o <= grant_dl || grant_ram || grant_rom;
		end
	end

	always_ff @(posedge clk_32) begin
		if (ram_fall && (!ram_pend_v || grant_ram)) begin
			ram_pend_addr <= ram_a_i;
			ram_pend_data <= ram_din_i;
			ram_pend_we   <= !we_n_i;
			ram_pend_sel  <= {uds_i, lds_i};
		end
		if (rom_fall && (!rom_pend_v || grant_rom))
			rom_pend_addr <= mbus_a_i;

		if (grant_dl) begin
			cand_src_o  <= st_mem_pkg::SRC_DL;
			cand_addr_o <= data_addr_i;
			cand_data_o <= data_in_reg_i;
			cand_we_o   <= 1'b1;
			cand_sel_o  <= 2'b11;
		end else if (grant_ram) begin
			// the oldest chipset event goes first
			cand_src_o  <= st_mem_pkg::SRC_RAM;
			cand_addr_o <= ram_pend_v ? ram_pend_addr : ram_a_i;
			cand_data_o <= ram_pend_v ? ram_pend_data : ram_din_i;
			cand_we_o   <= ram_pend_v ? ram_pend_we : !we_n_i;
			cand_sel_o  <= ram_pend_v ? ram_pend_sel : {uds_i, lds_i};
		end else if (grant_rom) begin
			cand_src_o  <= st_mem_pkg::SRC_ROM;
			cand_addr_o <= rom_pend_v ? rom_pend_addr : mbus_a_i;
			cand_data_o <= '0;
			cand_we_o   <= 1'b0;
			cand_sel_o  <= 2'b11;
		end
	end

endmodule

// ==== rtl/st_addr_window.sv ====
`timescale 1ns/1ps

module st_addr_window (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  logic                          cand_valid_i,
	input  st_mem_pkg::req_src_e          cand_src_i,
	input  logic [st_mem_pkg::ADDR_W:1]   cand_addr_i,
	input  logic [st_mem_pkg::DATA_W-1:0] cand_data_i,
	input  logic                          cand_we_i,
	input  logic [1:0]                    cand_sel_i,
	input  st_mem_pkg::mem_size_e         mem_size_i,
	input  logic                          data_download_i,
	input  logic [st_mem_pkg::ADDR_W:1]   data_addr_i,
	output logic                          push_o,
	output st_mem_pkg::mem_req_t          push_req_o
);

	logic                        tos192k;
	logic                        ram_en;
	logic                        accept;
	logic [st_mem_pkg::ADDR_W:1] rom_base;
	st_mem_pkg::mem_req_t        next_req;

	// ram top per size setting, 14M stops below the rom area at E00000
	always_comb begin
		case (mem_size_i)
			st_mem_pkg::MEM_512K: ram_en = (cand_addr_i[23:19] == 5'b00000);
			st_mem_pkg::MEM_1M:   ram_en = (cand_addr_i[23:20] == 4'b0000);
			st_mem_pkg::MEM_2M:   ram_en = (cand_addr_i[23:21] == 3'b000);
			st_mem_pkg::MEM_4M:   ram_en = (cand_addr_i[23:22] == 2'b00);
			st_mem_pkg::MEM_8M:   ram_en = !cand_addr_i[23];
			st_mem_pkg::MEM_14M:  ram_en = !(&cand_addr_i[23:21]);
			default:              ram_en = 1'b0;
		endcase
	end

	assign rom_base = tos192k ? st_mem_pkg::ROM_BASE_192K : st_mem_pkg::ROM_BASE_STD;

	always_comb begin
		next_req      = '0;
		next_req.addr = cand_addr_i;
		next_req.data = cand_data_i;
		accept        = 1'b0;
		case (cand_src_i)
			st_mem_pkg::SRC_DL: begin
				// downloads skip the window and write whole words
				accept       = 1'b1;
				next_req.we  = 1'b1;
				next_req.uds = 1'b1;
				next_req.lds = 1'b1;
			end
			st_mem_pkg::SRC_RAM: begin
				accept                    = ram_en;
				next_req.we               = cand_we_i;
				{next_req.uds, next_req.lds} = cand_sel_i;
			end
			st_mem_pkg::SRC_ROM: begin
				accept        = 1'b1;
				next_req.addr = {rom_base[23:18], cand_addr_i[17:1]};
				next_req.uds  = 1'b1;
				next_req.lds  = 1'b1;
				next_req.rom  = 1'b1;
			end
			default: accept = 1'b0;
		endcase
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			push_o  <= 1'b0;
			tos192k <= 1'b0;
		end else begin
			push_o <= cand_valid_i && accept;
			// 192K tos lives at FC0000, a normal one at E00000
			if (data_download_i) begin
				if (data_addr_i[23:18] == 6'b111111)
					tos192k <= 1'b1;
				else if (data_addr_i[23:20] == 4'hE)
					tos192k <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_32) begin
		if (cand_valid_i)
			push_req_o <= next_req;
	end

endmodule

// ==== rtl/st_req_fifo.sv ====
`timescale 1ns/1ps

module st_req_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  logic                 push_i,
	input  st_mem_pkg::mem_req_t push_req_i,
	input  logic                 pop_i,
	output st_mem_pkg::mem_req_t head_o,
	output logic                 not_empty_o,
	output logic                 overrun_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	st_mem_pkg::mem_req_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 full;
	logic                 do_push;
	logic                 do_pop;

	assign full        = (count == CNT_W'(FIFO_DEPTH));
	assign not_empty_o = (count != '0);
	assign do_push     = push_i && !full;
	assign do_pop      = pop_i && not_empty_o;
	assign head_o      = mem[rd_ptr];

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			overrun_o <= 1'b0;
		end else begin
			// pointers wrap at the depth, which need not be a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			// sticky until reset
			if (push_i && full)
				overrun_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_32) begin
		if (do_push)
			mem[wr_ptr] <= push_req_i;
	end

endmodule

// ==== rtl/st_wb_master.sv ====
`timescale 1ns/1ps

module st_wb_master (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  st_mem_pkg::mem_req_t          head_i,
	input  logic                          not_empty_i,
	input  logic                          ack_i,
	input  logic [st_mem_pkg::DATA_W-1:0] dat_i,
	output logic                          pop_o,
	output logic                          cyc_o,
	output logic                          stb_o,
	output logic                          we_o,
	output logic [st_mem_pkg::ADDR_W:1]   adr_o,
	output logic [1:0]                    sel_o,
	output logic [st_mem_pkg::DATA_W-1:0] dat_o,
	output logic [st_mem_pkg::DATA_W-1:0] ram_rdata_o,
	output logic                          ram_rvalid_o,
	output logic [st_mem_pkg::DATA_W-1:0] rom_rdata_o,
	output logic                          rom_rvalid_o
);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_e;

	state_e state;
	logic   rom_q;
	logic   rd_done;

	// take the head as soon as the bus is free
	assign pop_o   = (state == ST_IDLE) && not_empty_i;
	assign cyc_o   = (state == ST_BUSY);
	assign stb_o   = (state == ST_BUSY);
	assign rd_done = (state == ST_BUSY) && ack_i && !we_o;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			state        <= ST_IDLE;
			we_o         <= 1'b0;
			ram_rvalid_o <= 1'b0;
			rom_rvalid_o <= 1'b0;
		end else begin
			ram_rvalid_o <= rd_done && !rom_q;
			rom_rvalid_o <= rd_done && rom_q;
			case (state)
				ST_IDLE: begin
					if (not_empty_i) begin
						state <= ST_BUSY;
						we_o  <= head_i.we;
					end
				end
				ST_BUSY: begin
					if (ack_i) begin
						state <= ST_IDLE;
						we_o  <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// address, data and lanes stay put for the whole cycle
	always_ff @(posedge clk_32) begin
		if (pop_o) begin
			adr_o <= head_i.addr;
			dat_o <= head_i.data;
			sel_o <= {head_i.uds, head_i.lds};
			rom_q <= head_i.rom;
		end
		if (rd_done && !rom_q)
			ram_rdata_o <= dat_i;
		if (rd_done && rom_q)
			rom_rdata_o <= dat_i;
	end

endmodule

// ==== rtl/st_mem_mux.sv ====
`timescale 1ns/1ps

module st_mem_mux #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  logic                          ras_n_i,
	input  logic                          ref_i,
	input  logic                          we_n_i,
	input  logic                          uds_i,
	input  logic                          lds_i,
	input  logic [st_mem_pkg::ADDR_W:1]   ram_a_i,
	input  logic [st_mem_pkg::DATA_W-1:0] ram_din_i,
	input  logic                          rom_n_i,
	input  logic [st_mem_pkg::ADDR_W:1]   mbus_a_i,
	input  logic                          data_download_i,
	input  logic [st_mem_pkg::ADDR_W:1]   data_addr_i,
	input  logic [st_mem_pkg::DATA_W-1:0] data_in_reg_i,
	input  logic                          data_in_strobe_i,
	input  st_mem_pkg::mem_size_e         mem_size_i,
	input  logic                          wb_ack_i,
	input  logic [st_mem_pkg::DATA_W-1:0] wb_dat_i,
	output logic                          wb_cyc_o,
	output logic                          wb_stb_o,
	output logic                          wb_we_o,
	output logic [st_mem_pkg::ADDR_W:1]   wb_adr_o,
	output logic [1:0]                    wb_sel_o,
	output logic [st_mem_pkg::DATA_W-1:0] wb_dat_o,
	output logic [st_mem_pkg::DATA_W-1:0] ram_rdata_o,
	output logic                          ram_rvalid_o,
	output logic [st_mem_pkg::DATA_W-1:0] rom_rdata_o,
	output logic                          rom_rvalid_o,
	output logic                          overrun_o
);

	logic                          cand_valid;
	st_mem_pkg::req_src_e          cand_src;
	logic [st_mem_pkg::ADDR_W:1]   cand_addr;
	logic [st_mem_pkg::DATA_W-1:0] cand_data;
	logic                          cand_we;
	logic [1:0]                    cand_sel;
	logic                          push;
	st_mem_pkg::mem_req_t          push_req;
	st_mem_pkg::mem_req_t          head;
	logic                          not_empty;
	logic                          pop;

	st_req_capture u_capture (
		.clk_32, .xsint, .ras_n_i, .ref_i, .we_n_i, .uds_i, .lds_i, .ram_a_i, .ram_din_i,
		.rom_n_i, .mbus_a_i, .data_download_i, .data_addr_i, .data_in_reg_i, .data_in_strobe_i,
		.cand_valid_o (cand_valid),
		.cand_src_o   (cand_src),
		.cand_addr_o  (cand_addr),
		.cand_data_o  (cand_data),
		.cand_we_o    (cand_we),
		.cand_sel_o   (cand_sel)
	);

	st_addr_window u_window (
		.clk_32, .xsint, .mem_size_i, .data_download_i, .data_addr_i,
		.cand_valid_i (cand_valid),
		.cand_src_i   (cand_src),
		.cand_addr_i  (cand_addr),
		.cand_data_i  (cand_data),
		.cand_we_i    (cand_we),
		.cand_sel_i   (cand_sel),
		.push_o       (push),
		.push_req_o   (push_req)
	);

	st_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk_32, .xsint, .overrun_o,
		.push_i      (push),
		.push_req_i  (push_req),
		.pop_i       (pop),
		.head_o      (head),
		.not_empty_o (not_empty)
	);

	st_wb_master u_master (
		.clk_32, .xsint, .ram_rdata_o, .ram_rvalid_o, .rom_rdata_o, .rom_rvalid_o,
		.head_i      (head),
		.not_empty_i (not_empty),
		.ack_i       (wb_ack_i),
		.dat_i       (wb_dat_i),
		.pop_o       (pop),
		.cyc_o       (wb_cyc_o),
		.stb_o       (wb_stb_o),
		.we_o        (wb_we_o),
		.adr_o       (wb_adr_o),
		.sel_o       (wb_sel_o),
		.dat_o       (wb_dat_o)
	);

endmodule

// ==== test/st_mem_model.sv ====
`timescale 1ns/1ps

// wishbone slave memory with random wait states
module st_mem_model (
	input  logic        clk_32,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [23:1] adr_i,
	input  logic [1:0]  sel_i,
	input  logic [15:0] dat_i,
	input  logic        stall_i,
	output logic        ack_o,
	output logic [15:0] dat_o
);

	logic [15:0] mem [logic [23:1]];
	int          wait_cnt;

	initial begin
		ack_o    = 1'b0;
		dat_o    = '0;
		wait_cnt = 0;
	end

	always @(posedge clk_32) begin
		logic [15:0] word;
		ack_o <= 1'b0;
		// no new ack while the previous one is still on the bus
		if (cyc_i && stb_i && !ack_o && !stall_i) begin
			if (wait_cnt == 0) begin
				// never written locations read back their own address
				word = mem.exists(adr_i) ? mem[adr_i] : adr_i[16:1];
				if (we_i) begin
					if (sel_i[1])
						word[15:8] = dat_i[15:8];
					if (sel_i[0])
						word[7:0] = dat_i[7:0];
					mem[adr_i] = word;
				end
				dat_o    <= word;
				ack_o    <= 1'b1;
				wait_cnt <= $urandom_range(3, 0);
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

endmodule

// ==== test/tb_st_mem_mux.sv ====
`timescale 1ns/1ps

module tb_st_mem_mux;

	localparam int FIFO_DEPTH = 4;
	localparam int SRC_DL     = 0;
	localparam int SRC_RAM    = 1;
	localparam int SRC_ROM    = 2;
	// window 72, download 16, rom 14, back-pressure 7, coincident 4
	localparam int N_EVENTS   = 113;
	localparam int STALL_CYC  = 60;
	localparam int LIMIT      = 20 * N_EVENTS + STALL_CYC + 1000;

	typedef struct packed {
		logic [23:1] adr;
		logic [15:0] dat;
		logic        we;
		logic [1:0]  sel;
		logic        rom;
	} txn_t;

	logic                  clk_32;
	logic                  xsint;
	logic                  ras_n_i, ref_i, we_n_i, uds_i, lds_i, rom_n_i;
	logic [23:1]           ram_a_i, mbus_a_i, data_addr_i;
	logic [15:0]           ram_din_i, data_in_reg_i;
	logic                  data_download_i, data_in_strobe_i;
	st_mem_pkg::mem_size_e mem_size_i;
	logic                  wb_ack_i, wb_cyc_o, wb_stb_o, wb_we_o;
	logic [15:0]           wb_dat_i, wb_dat_o, ram_rdata_o, rom_rdata_o;
	logic [23:1]           wb_adr_o;
	logic [1:0]            wb_sel_o;
	logic                  ram_rvalid_o, rom_rvalid_o, overrun_o;
	logic                  model_stall;

	txn_t        exp_q [$];
	logic [15:0] ram_q [$];
	logic [15:0] rom_q [$];
	logic [15:0] shadow [logic [23:1]];
	int          errors;
	int          cycle_cnt;
	bit          tos_192k;
	string       test_name;
	// mirrors the divider and bus slot so that phase 3 is the precycle edge
	logic [3:0]  phase;

	st_mem_mux #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

	st_mem_model mem0 (
		.clk_32, .stall_i(model_stall),
		.cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o), .adr_i(wb_adr_o),
		.sel_i(wb_sel_o), .dat_i(wb_dat_o), .ack_o(wb_ack_i), .dat_o(wb_dat_i)
	);

	always #4 clk_32 = !clk_32;

	always @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			phase <= '0;
		else
			phase <= phase + 4'd1;
	end

	always @(posedge clk_32) begin
		cycle_cnt++;
		if (cycle_cnt >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// expected bus transaction for one source event
	function automatic bit expect_txn(input int src, input logic [23:1] a,
			input logic [15:0] d, input logic we, input logic [1:0] sel,
			input st_mem_pkg::mem_size_e size, input bit refresh, input bit tos,
			output txn_t t);
		logic [24:0] top;
		logic [23:0] base;
		bit          ok;
		t   = '{adr: a, dat: d, we: we, sel: sel, rom: 1'b0};
		ok  = 1'b0;
		top = '0;
		case (src)
			SRC_DL: begin
				t.we  = 1'b1;
				t.sel = 2'b11;
				ok    = 1'b1;
			end
			SRC_RAM: begin
				case (size)
					st_mem_pkg::MEM_512K: top = 25'h080000;
					st_mem_pkg::MEM_1M:   top = 25'h100000;
					st_mem_pkg::MEM_2M:   top = 25'h200000;
					st_mem_pkg::MEM_4M:   top = 25'h400000;
					st_mem_pkg::MEM_8M:   top = 25'h800000;
					st_mem_pkg::MEM_14M:  top = 25'hE00000;
					default:              top = 25'h0;
				endcase
				ok = !refresh && ({1'b0, a, 1'b0} < top);
			end
			default: begin
				base  = tos ? 24'hFC0000 : 24'hE00000;
				t.adr = base[23:1] | {6'b0, a[17:1]};
				t.dat = '0;
				t.we  = 1'b0;
				t.sel = 2'b11;
				t.rom = 1'b1;
				ok    = 1'b1;
			end
		endcase
		return ok;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("Fail %s %s expected %h actual %h", test_name, what, exp_v, act_v);
		end
	endtask

	// compares every acked bus cycle and every read return
	always @(posedge clk_32) begin
		txn_t        t;
		logic [15:0] w;
		if (wb_stb_o !== wb_cyc_o) begin
			errors++;
			$display("%s: wb_stb_o does not follow wb_cyc_o", test_name);
		end
		if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: unexpected bus cycle at %h", test_name, wb_adr_o);
			end else begin
				t = exp_q.pop_front();
				check_value("adr", t.adr, wb_adr_o);
				check_value("we", t.we, wb_we_o);
				check_value("sel", t.sel, wb_sel_o);
				if (t.we)
					check_value("wdata", t.dat, wb_dat_o);
				w = shadow.exists(t.adr) ? shadow[t.adr] : t.adr[16:1];
				if (t.we) begin
					if (t.sel[1])
						w[15:8] = t.dat[15:8];
					if (t.sel[0])
						w[7:0] = t.dat[7:0];
					shadow[t.adr] = w;
				end else if (t.rom) begin
					rom_q.push_back(w);
				end else begin
					ram_q.push_back(w);
				end
			end
		end
		if (ram_rvalid_o) begin
			if (ram_q.size() == 0) begin
				errors++;
				$display("%s: ram read data returned with no read pending", test_name);
			end else begin
				check_value("ram_rdata", ram_q.pop_front(), ram_rdata_o);
			end
		end
		if (rom_rvalid_o) begin
			if (rom_q.size() == 0) begin
				errors++;
				$display("%s: rom read data returned with no read pending", test_name);
			end else begin
				check_value("rom_rdata", rom_q.pop_front(), rom_rdata_o);
			end
		end
	end

	task automatic ram_access(input logic [23:1] a, input logic [15:0] d, input logic we,
			input logic [1:0] sel, input bit refresh, input bit keep);
		txn_t t;
		if (expect_txn(SRC_RAM, a, d, we, sel, mem_size_i, refresh, tos_192k, t) && keep)
			exp_q.push_back(t);
		@(posedge clk_32);
		ram_a_i   <= a;
		ram_din_i <= d;
		we_n_i    <= !we;
		{uds_i, lds_i} <= sel;
		ref_i     <= refresh;
		ras_n_i   <= 1'b0;
		repeat (3) @(posedge clk_32);
		ras_n_i <= 1'b1;
		ref_i   <= 1'b0;
		repeat (2) @(posedge clk_32);
	endtask

	task automatic rom_read(input logic [23:1] a);
		txn_t t;
		if (expect_txn(SRC_ROM, a, '0, 1'b0, 2'b11, mem_size_i, 1'b0, tos_192k, t))
			exp_q.push_back(t);
		@(posedge clk_32);
		mbus_a_i <= a;
		rom_n_i  <= 1'b0;
		repeat (3) @(posedge clk_32);
		rom_n_i <= 1'b1;
		repeat (2) @(posedge clk_32);
	endtask

	// queue the download write and follow the 192K rule
	task automatic note_download(input logic [23:1] a, input logic [15:0] d);
		txn_t t;
		if (expect_txn(SRC_DL, a, d, 1'b1, 2'b11, mem_size_i, 1'b0, tos_192k, t))
			exp_q.push_back(t);
		if (a[23:18] == 6'b111111)
			tos_192k = 1'b1;
		else if (a[23:20] == 4'hE)
			tos_192k = 1'b0;
	endtask

	task automatic dl_write(input logic [23:1] a, input logic [15:0] d);
		note_download(a, d);
		@(posedge clk_32);
		data_addr_i      <= a;
		data_in_reg_i    <= d;
		data_in_strobe_i <= !data_in_strobe_i;
		// the strobe is only looked at once per 16 clocks
		repeat (20) @(posedge clk_32);
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || ram_q.size() != 0 || rom_q.size() != 0 || wb_cyc_o)
			@(posedge clk_32);
		repeat (3) @(posedge clk_32);
	endtask

	initial begin
		logic [23:1] a;
		logic [23:1] dl_addr [8];
		logic [15:0] d;
		void'($urandom(32'h597b));
		clk_32 = 1'b0;
		xsint = 1'b0;
		ras_n_i = 1'b1;
		ref_i = 1'b0;
		we_n_i = 1'b1;
		uds_i = 1'b0;
		lds_i = 1'b0;
		rom_n_i = 1'b1;
		ram_a_i = '0;
		mbus_a_i = '0;
		data_addr_i = '0;
		ram_din_i = '0;
		data_in_reg_i = '0;
		data_download_i = 1'b0;
		data_in_strobe_i = 1'b0;
		mem_size_i = st_mem_pkg::MEM_14M;
		model_stall = 1'b0;
		errors = 0;
		cycle_cnt = 0;
		tos_192k = 1'b0;

		test_name = "reset";
		repeat (16) begin
			@(posedge clk_32);
			if (wb_cyc_o !== 1'b0 || ram_rvalid_o !== 1'b0 || rom_rvalid_o !== 1'b0 ||
					overrun_o !== 1'b0) begin
				errors++;
				$display("reset: outputs not low during reset");
			end
		end
		xsint <= 1'b1;
		repeat (4) begin
			@(posedge clk_32);
			if (wb_cyc_o !== 1'b0 || ram_rvalid_o !== 1'b0 || rom_rvalid_o !== 1'b0 ||
					overrun_o !== 1'b0) begin
				errors++;
				$display("reset: outputs not low right after reset");
			end
		end

		test_name = "window";
		for (int s = 0; s < 6; s++) begin
			mem_size_i <= st_mem_pkg::mem_size_e'(s);
			@(posedge clk_32);
			for (int i = 0; i < 12; i++) begin
				// shifting the 23 bit value spreads hits over every window size
				a = 23'($urandom) >> $urandom_range(10, 0);
				ram_access(a, 16'($urandom), 1'($urandom), 2'($urandom_range(3, 1)),
					$urandom_range(4, 0) == 0, 1'b1);
			end
			drain();
		end

		test_name = "download";
		mem_size_i <= st_mem_pkg::MEM_14M;
		data_download_i <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			dl_addr[i] = 23'($urandom_range(32'h3FFFF, 0));
			dl_write(dl_addr[i], 16'($urandom));
		end
		data_download_i <= 1'b0;
		drain();
		for (int i = 0; i < 8; i++)
			ram_access(dl_addr[i], '0, 1'b0, 2'b11, 1'b0, 1'b1);
		drain();

		test_name = "rom_remap";
		for (int i = 0; i < 4; i++)
			rom_read(23'($urandom));
		drain();
		data_download_i <= 1'b1;
		a = 23'h7E0000 | 23'($urandom_range(32'hFFFF, 0));
		dl_write(a, 16'($urandom));
		data_download_i <= 1'b0;
		drain();
		rom_read(a);
		for (int i = 0; i < 3; i++)
			rom_read(23'($urandom));
		drain();
		data_download_i <= 1'b1;
		dl_write(23'h700010, 16'($urandom));
		data_download_i <= 1'b0;
		drain();
		for (int i = 0; i < 4; i++)
			rom_read(23'($urandom));
		drain();

		// master holds one request and the queue the next FIFO_DEPTH
		test_name = "back_pressure";
		model_stall <= 1'b1;
		for (int i = 0; i < FIFO_DEPTH + 3; i++)
			ram_access(23'($urandom_range(32'hFFFF, 0)), 16'($urandom), 1'($urandom),
				2'b11, 1'b0, i <= FIFO_DEPTH);
		repeat (8) @(posedge clk_32);
		if (overrun_o !== 1'b1) begin
			errors++;
			$display("back_pressure: overrun_o did not rise with the queue full");
		end
		model_stall <= 1'b0;
		drain();

		test_name = "coincident";
		data_download_i <= 1'b1;
		for (int i = 0; i < 2; i++) begin
			// strobe toggle and row strobe fall both land on the precycle edge
			forever begin
				@(posedge clk_32);
				if (phase == 4'd1)
					break;
			end
			a = 23'($urandom_range(32'hFFFF, 0));
			d = 16'($urandom);
			note_download(a, d);
			data_addr_i      <= a;
			data_in_reg_i    <= d;
			data_in_strobe_i <= !data_in_strobe_i;
			ram_access(23'($urandom_range(32'hFFFF, 0)), 16'($urandom), 1'b1, 2'b11,
				1'b0, 1'b1);
			repeat (20) @(posedge clk_32);
		end
		data_download_i <= 1'b0;
		drain();

		$display("checks done with %0d errors", errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
rtl/st_mem_pkg.sv
rtl/st_req_capture.sv
rtl/st_addr_window.sv
rtl/st_req_fifo.sv
rtl/st_wb_master.sv
rtl/st_mem_mux.sv
test/st_mem_model.sv
test/tb_st_mem_mux.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vtb_st_mem_mux: all.f $(wildcard rtl/*.sv) $(wildcard test/*.sv)
	verilator --binary -Wno-fatal --top-module tb_st_mem_mux -f all.f -o Vtb_st_mem_mux

run: obj_dir/Vtb_st_mem_mux
	./obj_dir/Vtb_st_mem_mux | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
